// ==== hdl/qsys_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types and widths for the packet queue system.
// Imported by every RTL block of the queue system.
////////////////////////////////////////////////////////////

`default_nettype none

package qsys_pkg;

    ////////////////////////////////////////////////////////////
    // Data path

    // Width of one packet word
    localparam int WORD_W = 32;

    // One packet data word
    typedef logic [WORD_W-1:0] word_t;

    ////////////////////////////////////////////////////////////
    // Statistics

    // Width of the packet counters
    localparam int CNT_W = 32;

    // Packet counter value that saturates at all ones
    typedef logic [CNT_W-1:0] cnt_t;

    ////////////////////////////////////////////////////////////
    // Scheduler

    // Dequeue FSM states
    typedef enum logic {
        SCHED_IDLE,
        SCHED_SEND
    } sched_state_e;

endpackage

`default_nettype wire

// ==== hdl/admission_control.sv ====
////////////////////////////////////////////////////////////
// Admit or drop whole packets at the ingress of the queues.
// The decision is taken on the first word and held to the last.
////////////////////////////////////////////////////////////

`default_nettype none

module admission_control
    import qsys_pkg::*;
#(
    parameter int NUM_QUEUES  = 4,
    parameter int QUEUE_DEPTH = 32,
    parameter int MTU_WORDS   = 8,
    localparam int QW = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1,
    localparam int FW = $clog2(QUEUE_DEPTH + 1)
) (
    input  var logic                          packet_in,
    input  var logic                          rst_n,
    input  var logic                          in_valid,
    input  var logic                          in_last,
    input  var word_t                         in_data,
    input  var logic [QW-1:0]                 in_queue,
    input  var logic [NUM_QUEUES-1:0][FW-1:0] free_words,
    output logic                              wr_en,
    output logic                              wr_last,
    output word_t                             wr_data,
    output logic [QW-1:0]                     wr_queue
);

    localparam int CW = $clog2(MTU_WORDS + 1);

    logic          in_pkt;
    logic [QW-1:0] pkt_queue;
    logic          pkt_admit;
    logic [CW-1:0] word_cnt;
    logic          first_word;
    logic          admit_now;

    // First word of a packet opens the decision
    assign first_word = in_valid && !in_pkt;

    // Room for a full MTU packet is required up front
    assign admit_now = free_words[in_queue] >= FW'(MTU_WORDS);

    assign wr_en    = in_valid && (first_word ? admit_now : pkt_admit);
    assign wr_last  = in_last;
    assign wr_data  = in_data;
    assign wr_queue = first_word ? in_queue : pkt_queue;

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            in_pkt    <= 1'b0;
            pkt_queue <= '0;
            pkt_admit <= 1'b0;
            word_cnt  <= '0;
        end else if (in_valid) begin
            in_pkt <= !in_last;
            if (first_word) begin
                pkt_queue <= in_queue;
                pkt_admit <= admit_now;
                word_cnt  <= CW'(1);
            end else if (word_cnt != CW'(MTU_WORDS)) begin
                // Sticks at MTU so an overrun stays visible
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // Admitted packets never exceed the room that was checked for
    assert property (@(posedge packet_in) disable iff (!rst_n)
        (wr_en && !first_word) |-> (word_cnt < CW'(MTU_WORDS)))
        else $error("admitted packet longer than %0d words", MTU_WORDS);

endmodule

`default_nettype wire

// ==== hdl/queue_buffer.sv ====
////////////////////////////////////////////////////////////
// Per-queue circular word storage in one shared array.
// Reports free room and complete packets for every queue.
////////////////////////////////////////////////////////////

`default_nettype none

module queue_buffer
    import qsys_pkg::*;
#(
    parameter int NUM_QUEUES  = 4,
    parameter int QUEUE_DEPTH = 32,
    localparam int QW = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1,
    localparam int FW = $clog2(QUEUE_DEPTH + 1)
) (
    input  var logic                          packet_in,
    input  var logic                          rst_n,
    input  var logic                          wr_en,
    input  var logic                          wr_last,
    input  var word_t                         wr_data,
    input  var logic [QW-1:0]                 wr_queue,
    input  var logic                          rd_en,
    input  var logic [QW-1:0]                 rd_queue,
    output word_t                             rd_data,
    output logic                              rd_last,
    output logic [NUM_QUEUES-1:0][FW-1:0]     free_words,
    output logic [NUM_QUEUES-1:0]             pkt_ready
);

    localparam int PW = $clog2(QUEUE_DEPTH);
    localparam int MEM_WORDS = NUM_QUEUES * QUEUE_DEPTH;

    ////////////////////////////////////////////////////////////
    // Storage

    // Region of queue q starts at q * QUEUE_DEPTH
    word_t mem      [MEM_WORDS];
    logic  last_mem [MEM_WORDS];

    logic [PW-1:0] head    [NUM_QUEUES];
    logic [PW-1:0] tail    [NUM_QUEUES];
    logic [FW-1:0] occ     [NUM_QUEUES];
    logic [FW-1:0] pkt_cnt [NUM_QUEUES];

    logic [NUM_QUEUES-1:0] wr_hit;
    logic [NUM_QUEUES-1:0] rd_hit;

    always_ff @(posedge packet_in) begin
        if (wr_en) begin
            mem[{wr_queue, tail[wr_queue]}]      <= wr_data;
            last_mem[{wr_queue, tail[wr_queue]}] <= wr_last;
        end
    end

    // Head of the selected queue is read without latency
    assign rd_data = mem[{rd_queue, head[rd_queue]}];
    assign rd_last = last_mem[{rd_queue, head[rd_queue]}];

    ////////////////////////////////////////////////////////////
    // Queue state

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            wr_hit[q]     = wr_en && (wr_queue == QW'(q));
            rd_hit[q]     = rd_en && (rd_queue == QW'(q));
            free_words[q] = FW'(QUEUE_DEPTH) - occ[q];
            pkt_ready[q]  = pkt_cnt[q] != '0;
        end
    end

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                head[q]    <= '0;
                tail[q]    <= '0;
                occ[q]     <= '0;
                pkt_cnt[q] <= '0;
            end
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (wr_hit[q]) begin
                    tail[q] <= tail[q] + 1'b1;
                end
                if (rd_hit[q]) begin
                    head[q] <= head[q] + 1'b1;
                end
                occ[q] <= occ[q] + FW'(wr_hit[q]) - FW'(rd_hit[q]);
                // A written last adds a complete packet and a read last removes one
                pkt_cnt[q] <= pkt_cnt[q] + FW'(wr_hit[q] && wr_last)
                                         - FW'(rd_hit[q] && rd_last);
            end
        end
    end

    // Admission and scheduling must keep every queue in bounds
    assert property (@(posedge packet_in) disable iff (!rst_n)
        rd_en |-> (occ[rd_queue] != '0))
        else $error("read from empty queue %0d", rd_queue);

    assert property (@(posedge packet_in) disable iff (!rst_n)
        wr_en |-> (occ[wr_queue] != FW'(QUEUE_DEPTH)))
        else $error("write to full queue %0d", wr_queue);

endmodule

`default_nettype wire

// ==== hdl/dequeue_scheduler.sv ====
////////////////////////////////////////////////////////////
// Round-robin dequeue FSM, streams one whole packet at a time.
// Egress readiness is sampled only when a queue is chosen.
////////////////////////////////////////////////////////////

`default_nettype none

module dequeue_scheduler
    import qsys_pkg::*;
#(
    parameter int NUM_QUEUES = 4,
    localparam int QW = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1
) (
    input  var logic                  packet_in,
    input  var logic                  rst_n,
    input  var logic [NUM_QUEUES-1:0] pkt_ready,
    input  var logic [NUM_QUEUES-1:0] egr_ready,
    input  var word_t                 rd_data,
    input  var logic                  rd_last,
    output logic                      rd_en,
    output logic [QW-1:0]             rd_queue,
    output logic                      out_valid,
    output logic                      out_last,
    output word_t                     out_data,
    output logic [QW-1:0]             out_queue
);

    sched_state_e          state;
    logic [QW-1:0]         rr_ptr;
    logic [QW-1:0]         sel_queue;
    logic [NUM_QUEUES-1:0] eligible;
    logic                  found;
    logic [QW-1:0]         pick;

    assign eligible = pkt_ready & egr_ready;

    // Search starts at the queue after the last one served
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = rr_ptr;
        for (int i = 1; i <= NUM_QUEUES; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_QUEUES;
            if (!found && eligible[idx]) begin
                found = 1'b1;
                pick  = QW'(idx);
            end
        end
    end

    assign rd_en    = state == SCHED_SEND;
    assign rd_queue = sel_queue;

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            state     <= SCHED_IDLE;
            rr_ptr    <= QW'(NUM_QUEUES - 1);
            sel_queue <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            case (state)
                SCHED_IDLE: begin
                    if (found) begin
                        sel_queue <= pick;
                        state     <= SCHED_SEND;
                    end
                end
                SCHED_SEND: begin
                    out_valid <= 1'b1;
                    out_last  <= rd_last;
                    if (rd_last) begin
                        rr_ptr <= sel_queue;
                        state  <= SCHED_IDLE;
                    end
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    // Output payload follows the head word
    always_ff @(posedge packet_in) begin
        out_data  <= rd_data;
        out_queue <= sel_queue;
    end

    // The packet under transfer stays complete in its queue until its last read
    assert property (@(posedge packet_in) disable iff (!rst_n)
        (state == SCHED_SEND) |-> pkt_ready[sel_queue])
        else $error("sending from queue %0d without a complete packet", sel_queue);

endmodule

`default_nettype wire

// ==== hdl/pkt_counters.sv ====
////////////////////////////////////////////////////////////
// Saturating packet counters at input, enqueue and dequeue.
////////////////////////////////////////////////////////////

`default_nettype none

module pkt_counters
    import qsys_pkg::*;
(
    input  var logic packet_in,
    input  var logic rst_n,
    input  var logic in_valid,
    input  var logic in_last,
    input  var logic wr_en,
    input  var logic wr_last,
    input  var logic out_valid,
    input  var logic out_last,
    input  var logic in_cnt_clear,
    input  var logic enq_cnt_clear,
    input  var logic deq_cnt_clear,
    output cnt_t     in_pkt_cnt,
    output cnt_t     enq_pkt_cnt,
    output cnt_t     deq_pkt_cnt
);

    // Clear wins, then count up until all ones
    function automatic cnt_t cnt_next(input cnt_t cnt, input logic clr, input logic hit);
        cnt_t nxt;
        nxt = cnt;
        if (clr) begin
            nxt = '0;
        end else if (hit && !(&cnt)) begin
            nxt = cnt + 1'b1;
        end
        return nxt;
    endfunction

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            in_pkt_cnt  <= '0;
            enq_pkt_cnt <= '0;
            deq_pkt_cnt <= '0;
        end else begin
            in_pkt_cnt  <= cnt_next(in_pkt_cnt, in_cnt_clear, in_valid && in_last);
            enq_pkt_cnt <= cnt_next(enq_pkt_cnt, enq_cnt_clear, wr_en && wr_last);
            deq_pkt_cnt <= cnt_next(deq_pkt_cnt, deq_cnt_clear, out_valid && out_last);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pkt_queue_system.sv ====
////////////////////////////////////////////////////////////
// Top level that only connects the queue system blocks.
////////////////////////////////////////////////////////////

`default_nettype none

module pkt_queue_system
    import qsys_pkg::*;
#(
    parameter int NUM_QUEUES  = 4,
    parameter int QUEUE_DEPTH = 32,
    parameter int MTU_WORDS   = 8,
    localparam int QW = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1,
    localparam int FW = $clog2(QUEUE_DEPTH + 1)
) (
    input  var logic                  packet_in,
    input  var logic                  rst_n,
    input  var logic                  in_valid,
    input  var logic                  in_last,
    input  var word_t                 in_data,
    input  var logic [QW-1:0]         in_queue,
    input  var logic [NUM_QUEUES-1:0] egr_ready,
    input  var logic                  in_cnt_clear,
    input  var logic                  enq_cnt_clear,
    input  var logic                  deq_cnt_clear,
    output logic                      out_valid,
    output logic                      out_last,
    output word_t                     out_data,
    output logic [QW-1:0]             out_queue,
    output cnt_t                      in_pkt_cnt,
    output cnt_t                      enq_pkt_cnt,
    output cnt_t                      deq_pkt_cnt
);

    logic                          wr_en;
    logic                          wr_last;
    word_t                         wr_data;
    logic [QW-1:0]                 wr_queue;
    logic [NUM_QUEUES-1:0][FW-1:0] free_words;
    logic [NUM_QUEUES-1:0]         pkt_ready;
    logic                          rd_en;
    logic [QW-1:0]                 rd_queue;
    word_t                         rd_data;
    logic                          rd_last;

    ////////////////////////////////////////////////////////////
    // Enqueue side

    admission_control #(
        .NUM_QUEUES  (NUM_QUEUES),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MTU_WORDS   (MTU_WORDS)
    ) u_admission (
        .packet_in  (packet_in),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_data    (in_data),
        .in_queue   (in_queue),
        .free_words (free_words),
        .wr_en      (wr_en),
        .wr_last    (wr_last),
        .wr_data    (wr_data),
        .wr_queue   (wr_queue)
    );

    queue_buffer #(
        .NUM_QUEUES  (NUM_QUEUES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_buffer (
        .packet_in  (packet_in),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_last    (wr_last),
        .wr_data    (wr_data),
        .wr_queue   (wr_queue),
        .rd_en      (rd_en),
        .rd_queue   (rd_queue),
        .rd_data    (rd_data),
        .rd_last    (rd_last),
        .free_words (free_words),
        .pkt_ready  (pkt_ready)
    );

    ////////////////////////////////////////////////////////////
    // Dequeue side and statistics

    dequeue_scheduler #(
        .NUM_QUEUES (NUM_QUEUES)
    ) u_scheduler (
        .packet_in (packet_in),
        .rst_n     (rst_n),
        .pkt_ready (pkt_ready),
        .egr_ready (egr_ready),
        .rd_data   (rd_data),
        .rd_last   (rd_last),
        .rd_en     (rd_en),
        .rd_queue  (rd_queue),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_data  (out_data),
        .out_queue (out_queue)
    );

    pkt_counters u_counters (
        .packet_in     (packet_in),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_last       (in_last),
        .wr_en         (wr_en),
        .wr_last       (wr_last),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .in_cnt_clear  (in_cnt_clear),
        .enq_cnt_clear (enq_cnt_clear),
        .deq_cnt_clear (deq_cnt_clear),
        .in_pkt_cnt    (in_pkt_cnt),
        .enq_pkt_cnt   (enq_pkt_cnt),
        .deq_pkt_cnt   (deq_pkt_cnt)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_pkt_queue_system.sv ====
////////////////////////////////////////////////////////////
// Directed testbench for the packet queue system.
// Model queues apply the admission rule and check every output word.
////////////////////////////////////////////////////////////

`default_nettype none

module tb_pkt_queue_system;
    import qsys_pkg::*;

    localparam int NQ    = 4;
    localparam int DEPTH = 32;
    localparam int MTU   = 8;
    // Upper bound on the words sent by all tests together
    localparam int TOTAL_WORDS   = 40 * MTU;
    localparam int WATCHDOG_TIME = TOTAL_WORDS * 20 * 20 + 2000;

    logic          packet_in = 1'b0;
    logic          rst_n;
    logic          in_valid;
    logic          in_last;
    word_t         in_data;
    logic [1:0]    in_queue;
    logic [NQ-1:0] egr_ready;
    logic          in_cnt_clear;
    logic          enq_cnt_clear;
    logic          deq_cnt_clear;
    logic          out_valid;
    logic          out_last;
    word_t         out_data;
    logic [1:0]    out_queue;
    cnt_t          in_pkt_cnt;
    cnt_t          enq_pkt_cnt;
    cnt_t          deq_pkt_cnt;

    // Expected words per queue as {last, data}
    logic [32:0]   model_q [NQ][$];
    int            model_free [NQ];
    logic [NQ-1:0] held_mask;
    logic [31:0]   lfsr_state = 32'hcbc563ef;
    int            error_count;
    int            test_count;
    int            failed_tests;
    int            exp_in;
    int            exp_enq;
    int            exp_deq;

    pkt_queue_system dut (
        .packet_in     (packet_in),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_last       (in_last),
        .in_data       (in_data),
        .in_queue      (in_queue),
        .egr_ready     (egr_ready),
        .in_cnt_clear  (in_cnt_clear),
        .enq_cnt_clear (enq_cnt_clear),
        .deq_cnt_clear (deq_cnt_clear),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .out_data      (out_data),
        .out_queue     (out_queue),
        .in_pkt_cnt    (in_pkt_cnt),
        .enq_pkt_cnt   (enq_pkt_cnt),
        .deq_pkt_cnt   (deq_pkt_cnt)
    );

    always #10 packet_in = ~packet_in;

    ////////////////////////////////////////////////////////////
    // Helpers

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic send_packet(input int q, input int len);
        logic        admit;
        logic [31:0] w;
        admit = 1'b0;
        for (int i = 0; i < len; i++) begin
            w = next_bits(32);
            @(posedge packet_in);
            #2;
            if (i == 0) begin
                // Room for one MTU packet decides at the first word
                admit = model_free[q] >= MTU;
                exp_in++;
                if (admit) begin
                    exp_enq++;
                    exp_deq++;
                end
            end
            in_valid = 1'b1;
            in_last  = (i == len - 1);
            in_data  = w;
            in_queue = 2'(q);
            if (admit) begin
                model_q[q].push_back({in_last, w});
                model_free[q]--;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge packet_in);
            #2;
            in_valid = 1'b0;
            in_last  = 1'b0;
        end
    endtask

    task automatic wait_drain(input logic [NQ-1:0] mask);
        int pending;
        int cycles;
        cycles = 0;
        do begin
            @(posedge packet_in);
            pending = 0;
            for (int q = 0; q < NQ; q++) begin
                if (mask[q]) begin
                    pending += model_q[q].size();
                end
            end
            cycles++;
        end while (pending != 0 && cycles < 500);
        if (pending != 0) begin
            $display("Queues did not drain, %0d words never came out", pending);
            error_count++;
        end
        repeat (4) @(posedge packet_in);
    endtask

    task automatic check_counters();
        @(negedge packet_in);
        check_value("in_pkt_cnt", in_pkt_cnt, 32'(exp_in));
        check_value("enq_pkt_cnt", enq_pkt_cnt, 32'(exp_enq));
        check_value("deq_pkt_cnt", deq_pkt_cnt, 32'(exp_deq));
    endtask

    // Bit 0 input, bit 1 enqueue, bit 2 dequeue
    task automatic pulse_clear(input logic [2:0] sel);
        @(posedge packet_in);
        #2;
        {deq_cnt_clear, enq_cnt_clear, in_cnt_clear} = sel;
        @(posedge packet_in);
        #2;
        {deq_cnt_clear, enq_cnt_clear, in_cnt_clear} = 3'b000;
        if (sel[0]) exp_in = 0;
        if (sel[1]) exp_enq = 0;
        if (sel[2]) exp_deq = 0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor

    always @(negedge packet_in) begin
        logic [32:0] exp_word;
        int          q;
        if (rst_n && out_valid) begin
            q = int'(out_queue);
            if (held_mask[q]) begin
                $display("Queue %0d sent a word while its egress was held low", q);
                error_count++;
            end
            if (model_q[q].size() == 0) begin
                $display("Unexpected word 0x%h from queue %0d", out_data, q);
                error_count++;
            end else begin
                exp_word = model_q[q].pop_front();
                model_free[q]++;
                check_value("out_data", out_data, exp_word[31:0]);
                check_value("out_last", 32'(out_last), 32'(exp_word[32]));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Tests

    task automatic test_reset();
        int errs;
        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            @(negedge packet_in);
            check_value("out_valid", 32'(out_valid), 32'd0);
        end
        check_counters();
        finish_test("reset", errs);
    endtask

    task automatic test_single();
        int errs;
        errs = error_count;
        send_packet(0, 5);
        idle_cycles(1);
        wait_drain(4'hf);
        check_counters();
        finish_test("single_packet", errs);
    endtask

    task automatic test_all_queues();
        int errs;
        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            send_packet(i % NQ, 1 + int'(next_bits(3)) % MTU);
        end
        idle_cycles(1);
        wait_drain(4'hf);
        check_counters();
        finish_test("all_queues", errs);
    endtask

    task automatic test_held_queue();
        int errs;
        errs = error_count;
        @(posedge packet_in);
        #2;
        egr_ready = 4'b1101;
        held_mask = 4'b0010;
        for (int i = 0; i < 6; i++) begin
            send_packet(i % NQ, 2 + int'(next_bits(2)));
        end
        idle_cycles(20);
        wait_drain(4'b1101);
        @(posedge packet_in);
        #2;
        egr_ready = 4'hf;
        held_mask = 4'h0;
        wait_drain(4'hf);
        check_counters();
        finish_test("held_queue", errs);
    endtask

    task automatic test_admission_drop();
        int errs;
        int drops_before;
        int sent;
        errs = error_count;
        @(posedge packet_in);
        #2;
        egr_ready = 4'b1011;
        held_mask = 4'b0100;
        drops_before = exp_in - exp_enq;
        sent = 0;
        while ((exp_in - exp_enq) - drops_before < 2 && sent < 16) begin
            send_packet(2, 4 + int'(next_bits(2)));
            sent++;
        end
        idle_cycles(4);
        @(negedge packet_in);
        if (in_pkt_cnt - enq_pkt_cnt == cnt_t'(drops_before)) begin
            $display("No packet was dropped while queue 2 filled up");
            error_count++;
        end
        check_value("in_pkt_cnt", in_pkt_cnt, 32'(exp_in));
        check_value("enq_pkt_cnt", enq_pkt_cnt, 32'(exp_enq));
        @(posedge packet_in);
        #2;
        egr_ready = 4'hf;
        held_mask = 4'h0;
        wait_drain(4'hf);
        check_counters();
        finish_test("admission_drop", errs);
    endtask

    task automatic test_clears();
        int errs;
        errs = error_count;
        // A packet after each clear keeps the other counters nonzero
        for (int i = 0; i < 3; i++) begin
            pulse_clear(3'(1 << i));
            check_counters();
            send_packet(i, 3 + i);
            idle_cycles(1);
            wait_drain(4'hf);
            check_counters();
        end
        finish_test("counter_clears", errs);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_last       = 1'b0;
        in_data       = '0;
        in_queue      = '0;
        egr_ready     = 4'hf;
        in_cnt_clear  = 1'b0;
        enq_cnt_clear = 1'b0;
        deq_cnt_clear = 1'b0;
        held_mask     = 4'h0;
        error_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        exp_in        = 0;
        exp_enq       = 0;
        exp_deq       = 0;
        for (int q = 0; q < NQ; q++) begin
            model_free[q] = DEPTH;
        end
        repeat (4) @(posedge packet_in);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_single();
        test_all_queues();
        test_held_queue();
        test_admission_drop();
        test_clears();
        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout, the tests did not complete in %0d time units", WATCHDOG_TIME);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pkt_queue_system.f ====
hdl/qsys_pkg.sv
hdl/admission_control.sv
hdl/queue_buffer.sv
hdl/dequeue_scheduler.sv
hdl/pkt_counters.sv
hdl/pkt_queue_system.sv
testbench/tb_pkt_queue_system.sv

// ==== Makefile ====
TOP = tb_pkt_queue_system

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f pkt_queue_system.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
